// ==== verilog/core_pkg.sv ====
`default_nettype none

package core_pkg;

  localparam int insn_bits    = 32;
  localparam int gpr_idx_bits = 5;
  localparam int data_bits    = 64;

  // x31 reads as zero, x30 takes the return address of BL/BLR
  localparam logic [gpr_idx_bits-1:0] zero_reg = 5'd31;
  localparam logic [gpr_idx_bits-1:0] link_reg = 5'd30;

  // Decoded instruction class
  typedef enum logic [5:0] {
    op_ldur,
    op_stur,
    op_ldp,
    op_stp,
    op_movk,
    op_movz,
    op_adr,
    op_adrp,
    op_add,
    op_adds,
    op_sub,
    op_subs,
    op_and,
    op_ands,
    op_orr,
    op_orn,
    op_eor,
    op_ubfm,
    op_sbfm,
    op_csel,
    op_csinc,
    op_csinv,
    op_csneg,
    op_b,
    op_b_cond,
    op_bl,
    op_blr,
    op_br,
    op_ret,
    op_cbz,
    op_cbnz,
    op_nop,
    op_hlt,
    op_err
  } opcode_t;

  typedef enum logic [3:0] {
    alu_plus,
    alu_minus,
    alu_and,
    alu_or,
    alu_orn,
    alu_eor,
    alu_ubfm,
    alu_sbfm,
    alu_mov,
    alu_csel,
    alu_csinc,
    alu_csinv,
    alu_csneg,
    alu_pass
  } alu_op_t;

  typedef enum logic {
    fu_alu,
    fu_ls
  } fu_t;

  // A64 condition field encoding
  typedef enum logic [3:0] {
    c_eq, c_ne, c_cs, c_cc, c_mi, c_pl, c_vs, c_vc,
    c_hi, c_ls, c_ge, c_lt, c_gt, c_le, c_al, c_nv
  } cond_t;

endpackage

`default_nettype wire

// ==== verilog/fetch_buffer.sv ====
`default_nettype none

module fetch_buffer
  import core_pkg::*;
#(
  parameter int fetch_depth = 4
) (
  input  wire                  in_clk,
  input  wire                  arst_n,
  input  wire                  in_fetch_done,
  input  wire [insn_bits-1:0]  in_fetch_insnbits,
  input  wire                  in_stall,
  output logic                 buf_done,
  output logic [insn_bits-1:0] buf_insnbits,
  output logic                 fetch_overflow
);

  localparam int ptr_bits = $clog2(fetch_depth);

  logic [insn_bits-1:0] mem [fetch_depth];
  logic [ptr_bits-1:0]  rd_ptr;
  logic [ptr_bits-1:0]  wr_ptr;
  logic [ptr_bits:0]    count;
  logic                 full;
  logic                 push;
  logic                 pop;

  assign full = (count == (ptr_bits + 1)'(fetch_depth));
  // A word written this edge is only visible to the pop on the next one
  assign pop  = (count != '0) && !in_stall;
  assign push = in_fetch_done && !full;

  always_ff @(posedge in_clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_ptr         <= '0;
      wr_ptr         <= '0;
      count          <= '0;
      buf_done       <= 1'b0;
      fetch_overflow <= 1'b0;
    end else begin
      buf_done <= pop;
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      count <= count + (ptr_bits + 1)'(push) - (ptr_bits + 1)'(pop);
      // Sticky until reset
      if (in_fetch_done && full) begin
        fetch_overflow <= 1'b1;
      end
    end
  end

  always_ff @(posedge in_clk) begin
    if (push) begin
      mem[wr_ptr] <= in_fetch_insnbits;
    end
    if (pop) begin
      buf_insnbits <= mem[rd_ptr];
    end
  end

  a_count_bound : assert property (@(posedge in_clk) disable iff (!arst_n)
    count <= (ptr_bits + 1)'(fetch_depth));

endmodule

`default_nettype wire

// ==== verilog/dispatch.sv ====
`default_nettype none

module dispatch
  import core_pkg::*;
(
  input  wire                     in_clk,
  input  wire                     arst_n,
  input  wire                     buf_done,
  input  wire [insn_bits-1:0]     buf_insnbits,
  output logic                    dec_done,
  output opcode_t                 dec_op,
  output alu_op_t                 dec_alu_op,
  output fu_t                     dec_fu,
  output logic                    dec_set_nzcv,
  output logic                    dec_uses_nzcv,
  output logic                    dec_use_imm,
  output logic [data_bits-1:0]    dec_imm,
  output cond_t                   dec_cond,
  output logic [gpr_idx_bits-1:0] dec_src1,
  output logic [gpr_idx_bits-1:0] dec_src2,
  output logic [gpr_idx_bits-1:0] dec_dst
);

  logic [insn_bits-1:0] insn;

  always_ff @(posedge in_clk or negedge arst_n) begin
    if (!arst_n) begin
      dec_done <= 1'b0;
    end else begin
      dec_done <= buf_done;
    end
  end

  always_ff @(posedge in_clk) begin
    if (buf_done) begin
      insn <= buf_insnbits;
    end
  end

  // Opcode match, 64-bit forms only
  always_comb begin
    casez (insn)
      32'b1111_1000_010?_????_????_00??_????_????: dec_op = op_ldur;
      32'b1111_1000_000?_????_????_00??_????_????: dec_op = op_stur;
      32'b1010_1000_11??_????_????_????_????_????: dec_op = op_ldp;
      32'b1010_1001_00??_????_????_????_????_????: dec_op = op_stp;
      32'b1111_0010_1???_????_????_????_????_????: dec_op = op_movk;
      32'b1101_0010_1???_????_????_????_????_????: dec_op = op_movz;
      32'b0??1_0000_????_????_????_????_????_????: dec_op = op_adr;
      32'b1??1_0000_????_????_????_????_????_????: dec_op = op_adrp;
      32'b1001_0001_0???_????_????_????_????_????: dec_op = op_add;
      32'b1010_1011_000?_????_????_????_????_????: dec_op = op_adds;
      32'b1101_0001_0???_????_????_????_????_????: dec_op = op_sub;
      32'b1110_1011_000?_????_????_????_????_????: dec_op = op_subs;
      32'b1001_0010_00??_????_????_????_????_????: dec_op = op_and;
      32'b1110_1010_000?_????_????_????_????_????: dec_op = op_ands;
      32'b1010_1010_000?_????_????_????_????_????: dec_op = op_orr;
      32'b1010_1010_001?_????_????_????_????_????: dec_op = op_orn;
      32'b1100_1010_000?_????_????_????_????_????: dec_op = op_eor;
      32'b1101_0011_01??_????_????_????_????_????: dec_op = op_ubfm;
      32'b1001_0011_01??_????_????_????_????_????: dec_op = op_sbfm;
      32'b1001_1010_100?_????_????_00??_????_????: dec_op = op_csel;
      32'b1001_1010_100?_????_????_01??_????_????: dec_op = op_csinc;
      32'b1101_1010_100?_????_????_00??_????_????: dec_op = op_csinv;
      32'b1101_1010_100?_????_????_01??_????_????: dec_op = op_csneg;
      32'b0001_01??_????_????_????_????_????_????: dec_op = op_b;
      32'b0101_0100_????_????_????_????_???0_????: dec_op = op_b_cond;
      32'b1001_01??_????_????_????_????_????_????: dec_op = op_bl;
      32'b1101_0110_0011_1111_0000_00??_???0_0000: dec_op = op_blr;
      32'b1101_0110_0001_1111_0000_00??_???0_0000: dec_op = op_br;
      32'b1101_0110_0101_1111_0000_00??_???0_0000: dec_op = op_ret;
      32'b1011_0100_????_????_????_????_????_????: dec_op = op_cbz;
      32'b1011_0101_????_????_????_????_????_????: dec_op = op_cbnz;
      32'b1101_0101_0000_0011_0010_0000_0001_1111: dec_op = op_nop;
      32'b1101_0100_010?_????_????_????_???0_0000: dec_op = op_hlt;
      default:                                     dec_op = op_err;
    endcase
  end

  // Register indices, immediate and condition field
  always_comb begin
    case (dec_op)
      op_bl, op_blr: dec_dst = link_reg;
      op_b, op_b_cond, op_br, op_ret, op_cbz, op_cbnz,
      op_nop, op_hlt, op_stur, op_stp: dec_dst = zero_reg;
      default: dec_dst = insn[4:0];
    endcase

    case (dec_op)
      op_cbz, op_cbnz: dec_src1 = insn[4:0];
      op_movk, op_movz, op_adr, op_adrp,
      op_b, op_b_cond, op_bl, op_nop: dec_src1 = zero_reg;
      default: dec_src1 = insn[9:5];
    endcase

    case (dec_op)
      op_adds, op_subs, op_ands, op_orr, op_orn, op_eor,
      op_csel, op_csinc, op_csinv, op_csneg: dec_src2 = insn[20:16];
      // Store data register
      op_stur: dec_src2 = insn[4:0];
      default: dec_src2 = zero_reg;
    endcase

    dec_use_imm = 1'b1;
    case (dec_op)
      op_ldur, op_stur: dec_imm = data_bits'(insn[20:12]);
      op_add, op_sub, op_ubfm, op_sbfm: dec_imm = data_bits'(insn[21:10]);
      op_movk, op_movz: dec_imm = data_bits'(insn[20:5]);
      default: begin
        dec_imm     = '0;
        dec_use_imm = 1'b0;
      end
    endcase

    case (dec_op)
      op_b_cond: dec_cond = cond_t'(insn[3:0]);
      op_csel, op_csinc, op_csinv, op_csneg: dec_cond = cond_t'(insn[15:12]);
      default: dec_cond = c_eq;
    endcase
  end

  // Control fields
  always_comb begin
    case (dec_op)
      op_ldur, op_stur, op_ldp, op_stp,
      op_add, op_adds, op_adr, op_adrp: dec_alu_op = alu_plus;
      op_sub, op_subs: dec_alu_op = alu_minus;
      op_and, op_ands: dec_alu_op = alu_and;
      op_orr:   dec_alu_op = alu_or;
      op_orn:   dec_alu_op = alu_orn;
      op_eor:   dec_alu_op = alu_eor;
      op_ubfm:  dec_alu_op = alu_ubfm;
      op_sbfm:  dec_alu_op = alu_sbfm;
      op_movk, op_movz: dec_alu_op = alu_mov;
      op_csel:  dec_alu_op = alu_csel;
      op_csinc: dec_alu_op = alu_csinc;
      op_csinv: dec_alu_op = alu_csinv;
      op_csneg: dec_alu_op = alu_csneg;
      default:  dec_alu_op = alu_pass;
    endcase

    dec_fu = (dec_op inside {op_ldur, op_stur, op_ldp, op_stp}) ? fu_ls : fu_alu;
    dec_set_nzcv  = dec_op inside {op_adds, op_subs, op_ands};
    dec_uses_nzcv = dec_op inside {op_b_cond, op_csel, op_csinc, op_csinv, op_csneg};
  end

endmodule

`default_nettype wire

// ==== verilog/reg_file.sv ====
`default_nettype none

module reg_file
  import core_pkg::*;
(
  input  wire                     in_clk,
  input  wire                     arst_n,
  input  wire                     wb_en,
  input  wire  [gpr_idx_bits-1:0] wb_idx,
  input  wire  [data_bits-1:0]    wb_data,
  input  wire  [gpr_idx_bits-1:0] rd_idx_a,
  input  wire  [gpr_idx_bits-1:0] rd_idx_b,
  input  wire  [gpr_idx_bits-1:0] rd_idx_c,
  output logic [data_bits-1:0]    rd_data_a,
  output logic [data_bits-1:0]    rd_data_b,
  output logic [data_bits-1:0]    rd_data_c
);

  localparam int num_regs = 2 ** gpr_idx_bits;

  logic [data_bits-1:0] regs [num_regs];

  // Write lands at the edge, so a same-cycle read sees the old value
  always_ff @(posedge in_clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_en && (wb_idx != zero_reg)) begin
      regs[wb_idx] <= wb_data;
    end
  end

  // Zero register reads as zero on every port
  assign rd_data_a = (rd_idx_a == zero_reg) ? '0 : regs[rd_idx_a];
  assign rd_data_b = (rd_idx_b == zero_reg) ? '0 : regs[rd_idx_b];
  assign rd_data_c = (rd_idx_c == zero_reg) ? '0 : regs[rd_idx_c];

  a_wb_idx_known : assert property (@(posedge in_clk) disable iff (!arst_n)
    wb_en |-> !$isunknown(wb_idx));

endmodule

`default_nettype wire

// ==== verilog/operand_stage.sv ====
`default_nettype none

module operand_stage
  import core_pkg::*;
(
  input  wire                      in_clk,
  input  wire                      arst_n,
  input  wire                      dec_done,
  input  wire opcode_t             dec_op,
  input  wire alu_op_t             dec_alu_op,
  input  wire fu_t                 dec_fu,
  input  wire                      dec_set_nzcv,
  input  wire                      dec_uses_nzcv,
  input  wire                      dec_use_imm,
  input  wire  [data_bits-1:0]     dec_imm,
  input  wire cond_t               dec_cond,
  input  wire  [gpr_idx_bits-1:0]  dec_src1,
  input  wire  [gpr_idx_bits-1:0]  dec_src2,
  input  wire  [gpr_idx_bits-1:0]  dec_dst,
  input  wire  [data_bits-1:0]     rd_data_a,
  input  wire  [data_bits-1:0]     rd_data_b,
  output logic [gpr_idx_bits-1:0]  rd_idx_a,
  output logic [gpr_idx_bits-1:0]  rd_idx_b,
  output logic                     issue_valid,
  output opcode_t                  issue_op,
  output alu_op_t                  issue_alu_op,
  output fu_t                      issue_fu,
  output logic                     issue_set_nzcv,
  output logic                     issue_uses_nzcv,
  output cond_t                    issue_cond,
  output logic [gpr_idx_bits-1:0]  issue_dst,
  output logic [data_bits-1:0]     issue_opa,
  output logic [data_bits-1:0]     issue_opb,
  output logic [data_bits-1:0]     issue_stb_val
);

  assign rd_idx_a = dec_src1;
  assign rd_idx_b = dec_src2;

  always_ff @(posedge in_clk or negedge arst_n) begin
    if (!arst_n) begin
      issue_valid <= 1'b0;
    end else begin
      issue_valid <= dec_done;
    end
  end

  // Bundle payload, only meaningful while issue_valid is high
  always_ff @(posedge in_clk) begin
    if (dec_done) begin
      issue_op        <= dec_op;
      issue_alu_op    <= dec_alu_op;
      issue_fu        <= dec_fu;
      issue_set_nzcv  <= dec_set_nzcv;
      issue_uses_nzcv <= dec_uses_nzcv;
      issue_cond      <= dec_cond;
      issue_dst       <= dec_dst;
      issue_opa       <= rd_data_a;
      issue_opb       <= dec_use_imm ? dec_imm : rd_data_b;
      // Port b also carries the STUR data register
      issue_stb_val   <= rd_data_b;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/frontend_top.sv ====
`default_nettype none

module frontend_top
  import core_pkg::*;
#(
  parameter int fetch_depth = 4
) (
  input  wire                      in_clk,
  input  wire                      arst_n,
  input  wire                      in_fetch_done,
  input  wire  [insn_bits-1:0]     in_fetch_insnbits,
  input  wire                      in_stall,
  input  wire                      wb_en,
  input  wire  [gpr_idx_bits-1:0]  wb_idx,
  input  wire  [data_bits-1:0]     wb_data,
  output logic                     fetch_overflow,
  output logic                     issue_valid,
  output opcode_t                  issue_op,
  output alu_op_t                  issue_alu_op,
  output fu_t                      issue_fu,
  output logic                     issue_set_nzcv,
  output logic                     issue_uses_nzcv,
  output cond_t                    issue_cond,
  output logic [gpr_idx_bits-1:0]  issue_dst,
  output logic [data_bits-1:0]     issue_opa,
  output logic [data_bits-1:0]     issue_opb,
  output logic [data_bits-1:0]     issue_stb_val
);

  logic                    buf_done;
  logic [insn_bits-1:0]    buf_insnbits;
  logic                    dec_done;
  opcode_t                 dec_op;
  alu_op_t                 dec_alu_op;
  fu_t                     dec_fu;
  logic                    dec_set_nzcv;
  logic                    dec_uses_nzcv;
  logic                    dec_use_imm;
  logic [data_bits-1:0]    dec_imm;
  cond_t                   dec_cond;
  logic [gpr_idx_bits-1:0] dec_src1;
  logic [gpr_idx_bits-1:0] dec_src2;
  logic [gpr_idx_bits-1:0] dec_dst;
  logic [gpr_idx_bits-1:0] rd_idx_a;
  logic [gpr_idx_bits-1:0] rd_idx_b;
  logic [data_bits-1:0]    rd_data_a;
  logic [data_bits-1:0]    rd_data_b;

  fetch_buffer #(
    .fetch_depth(fetch_depth)
  ) u_fetch_buffer (
    .in_clk           (in_clk),
    .arst_n           (arst_n),
    .in_fetch_done    (in_fetch_done),
    .in_fetch_insnbits(in_fetch_insnbits),
    .in_stall         (in_stall),
    .buf_done         (buf_done),
    .buf_insnbits     (buf_insnbits),
    .fetch_overflow   (fetch_overflow)
  );

  dispatch u_dispatch (
    .in_clk       (in_clk),
    .arst_n       (arst_n),
    .buf_done     (buf_done),
    .buf_insnbits (buf_insnbits),
    .dec_done     (dec_done),
    .dec_op       (dec_op),
    .dec_alu_op   (dec_alu_op),
    .dec_fu       (dec_fu),
    .dec_set_nzcv (dec_set_nzcv),
    .dec_uses_nzcv(dec_uses_nzcv),
    .dec_use_imm  (dec_use_imm),
    .dec_imm      (dec_imm),
    .dec_cond     (dec_cond),
    .dec_src1     (dec_src1),
    .dec_src2     (dec_src2),
    .dec_dst      (dec_dst)
  );

  // Port c is reserved for STP data and reads x31 for now
  reg_file u_reg_file (
    .in_clk   (in_clk),
    .arst_n   (arst_n),
    .wb_en    (wb_en),
    .wb_idx   (wb_idx),
    .wb_data  (wb_data),
    .rd_idx_a (rd_idx_a),
    .rd_idx_b (rd_idx_b),
    .rd_idx_c (zero_reg),
    .rd_data_a(rd_data_a),
    .rd_data_b(rd_data_b),
    .rd_data_c()
  );

  operand_stage u_operand_stage (
    .in_clk         (in_clk),
    .arst_n         (arst_n),
    .dec_done       (dec_done),
    .dec_op         (dec_op),
    .dec_alu_op     (dec_alu_op),
    .dec_fu         (dec_fu),
    .dec_set_nzcv   (dec_set_nzcv),
    .dec_uses_nzcv  (dec_uses_nzcv),
    .dec_use_imm    (dec_use_imm),
    .dec_imm        (dec_imm),
    .dec_cond       (dec_cond),
    .dec_src1       (dec_src1),
    .dec_src2       (dec_src2),
    .dec_dst        (dec_dst),
    .rd_data_a      (rd_data_a),
    .rd_data_b      (rd_data_b),
    .rd_idx_a       (rd_idx_a),
    .rd_idx_b       (rd_idx_b),
    .issue_valid    (issue_valid),
    .issue_op       (issue_op),
    .issue_alu_op   (issue_alu_op),
    .issue_fu       (issue_fu),
    .issue_set_nzcv (issue_set_nzcv),
    .issue_uses_nzcv(issue_uses_nzcv),
    .issue_cond     (issue_cond),
    .issue_dst      (issue_dst),
    .issue_opa      (issue_opa),
    .issue_opb      (issue_opb),
    .issue_stb_val  (issue_stb_val)
  );

endmodule

`default_nettype wire

// ==== verification/frontend_tb.sv ====
`default_nettype none

module frontend_tb
  import core_pkg::*;
();

  localparam int fetch_depth    = 4;
  localparam int n_words        = 23;
  localparam int timeout_cycles = 20 * n_words + 50;

  // One issue bundle, as observed or as predicted
  typedef struct packed {
    opcode_t              op;
    alu_op_t              alu;
    fu_t                  fu;
    logic                 set_nzcv;
    logic                 uses_nzcv;
    cond_t                cond;
    logic [4:0]           dst;
    logic [data_bits-1:0] opa;
    logic [data_bits-1:0] opb;
    logic [data_bits-1:0] stb;
  } bundle_t;

  logic                    in_clk;
  logic                    arst_n;
  logic                    in_fetch_done;
  logic [insn_bits-1:0]    in_fetch_insnbits;
  logic                    in_stall;
  logic                    wb_en;
  logic [gpr_idx_bits-1:0] wb_idx;
  logic [data_bits-1:0]    wb_data;
  logic                    fetch_overflow;
  logic                    issue_valid;
  opcode_t                 issue_op;
  alu_op_t                 issue_alu_op;
  fu_t                     issue_fu;
  logic                    issue_set_nzcv;
  logic                    issue_uses_nzcv;
  cond_t                   issue_cond;
  logic [gpr_idx_bits-1:0] issue_dst;
  logic [data_bits-1:0]    issue_opa;
  logic [data_bits-1:0]    issue_opb;
  logic [data_bits-1:0]    issue_stb_val;

  bundle_t              exp_q[$];
  bundle_t              got_q[$];
  int                   got_cyc[$];
  logic [data_bits-1:0] model [32];
  int                   cycle_cnt = 0;
  int                   errors;
  int                   checks;

  frontend_top #(
    .fetch_depth(fetch_depth)
  ) dut0 (
    .in_clk           (in_clk),
    .arst_n           (arst_n),
    .in_fetch_done    (in_fetch_done),
    .in_fetch_insnbits(in_fetch_insnbits),
    .in_stall         (in_stall),
    .wb_en            (wb_en),
    .wb_idx           (wb_idx),
    .wb_data          (wb_data),
    .fetch_overflow   (fetch_overflow),
    .issue_valid      (issue_valid),
    .issue_op         (issue_op),
    .issue_alu_op     (issue_alu_op),
    .issue_fu         (issue_fu),
    .issue_set_nzcv   (issue_set_nzcv),
    .issue_uses_nzcv  (issue_uses_nzcv),
    .issue_cond       (issue_cond),
    .issue_dst        (issue_dst),
    .issue_opa        (issue_opa),
    .issue_opb        (issue_opb),
    .issue_stb_val    (issue_stb_val)
  );

  initial begin
    in_clk = 1'b0;
  end

  always #4 in_clk = ~in_clk;

  function automatic bundle_t make_bundle(opcode_t op, alu_op_t alu, fu_t fu,
                                          logic set_nzcv, logic uses_nzcv, cond_t cond,
                                          logic [4:0] dst, logic [63:0] opa,
                                          logic [63:0] opb, logic [63:0] stb);
    bundle_t b;
    b.op        = op;
    b.alu       = alu;
    b.fu        = fu;
    b.set_nzcv  = set_nzcv;
    b.uses_nzcv = uses_nzcv;
    b.cond      = cond;
    b.dst       = dst;
    b.opa       = opa;
    b.opb       = opb;
    b.stb       = stb;
    return b;
  endfunction

  // Architectural register value, x31 always zero
  function automatic logic [63:0] reg_value(int idx);
    return (idx == 31) ? 64'd0 : model[idx];
  endfunction

  function automatic logic [31:0] place_field(logic [31:0] val, int lsb);
    return val << lsb;
  endfunction

  // Sample the bundle in mid-cycle, well away from the edge
  always @(negedge in_clk) begin
    if (issue_valid === 1'b1) begin
      got_q.push_back(make_bundle(issue_op, issue_alu_op, issue_fu, issue_set_nzcv,
                                  issue_uses_nzcv, issue_cond, issue_dst, issue_opa,
                                  issue_opb, issue_stb_val));
      got_cyc.push_back(cycle_cnt);
    end
  end

  always @(posedge in_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= timeout_cycles) begin
      $display("timeout after %0d cycles with %0d issues still awaited",
               cycle_cnt, exp_q.size() - got_q.size());
      $display("sim failed");
      $finish;
    end
  end

  task automatic check(string name, logic [63:0] exp, logic [63:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("[ERROR] %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic write_reg(logic [4:0] idx, logic [63:0] data);
    wb_en   = 1'b1;
    wb_idx  = idx;
    wb_data = data;
    @(posedge in_clk);
    #1;
    wb_en = 1'b0;
    // Writes to x31 are discarded
    if (idx != zero_reg) begin
      model[idx] = data;
    end
  endtask

  task automatic send_word(logic [31:0] w);
    in_fetch_done     = 1'b1;
    in_fetch_insnbits = w;
    @(posedge in_clk);
    #1;
    in_fetch_done = 1'b0;
  endtask

  task automatic send_expect(logic [31:0] w, bundle_t e);
    exp_q.push_back(e);
    send_word(w);
  endtask

  // Wait for every predicted issue, then compare in arrival order
  task automatic compare_all(string name);
    bundle_t e;
    bundle_t g;
    int      i;
    while (got_q.size() < exp_q.size()) begin
      @(posedge in_clk);
      #1;
    end
    i = 0;
    while (exp_q.size() > 0) begin
      e = exp_q.pop_front();
      g = got_q.pop_front();
      void'(got_cyc.pop_front());
      check($sformatf("%s[%0d] op", name, i), 64'(e.op), 64'(g.op));
      check($sformatf("%s[%0d] alu_op", name, i), 64'(e.alu), 64'(g.alu));
      check($sformatf("%s[%0d] fu", name, i), 64'(e.fu), 64'(g.fu));
      check($sformatf("%s[%0d] set_nzcv", name, i), 64'(e.set_nzcv), 64'(g.set_nzcv));
      check($sformatf("%s[%0d] uses_nzcv", name, i), 64'(e.uses_nzcv), 64'(g.uses_nzcv));
      check($sformatf("%s[%0d] cond", name, i), 64'(e.cond), 64'(g.cond));
      check($sformatf("%s[%0d] dst", name, i), 64'(e.dst), 64'(g.dst));
      check($sformatf("%s[%0d] opa", name, i), e.opa, g.opa);
      check($sformatf("%s[%0d] opb", name, i), e.opb, g.opb);
      check($sformatf("%s[%0d] stb_val", name, i), e.stb, g.stb);
      i++;
    end
  endtask

  task automatic test_reg_form();
    // SUBS x3, x1, x2 then ORR and EOR with the same registers
    send_expect(32'hEB000000 | place_field(2, 16) | place_field(1, 5) | place_field(3, 0),
                make_bundle(op_subs, alu_minus, fu_alu, 1'b1, 1'b0, c_eq, 5'd3,
                            reg_value(1), reg_value(2), reg_value(2)));
    send_expect(32'hAA000000 | place_field(2, 16) | place_field(1, 5) | place_field(3, 0),
                make_bundle(op_orr, alu_or, fu_alu, 1'b0, 1'b0, c_eq, 5'd3,
                            reg_value(1), reg_value(2), reg_value(2)));
    send_expect(32'hCA000000 | place_field(2, 16) | place_field(1, 5) | place_field(3, 0),
                make_bundle(op_eor, alu_eor, fu_alu, 1'b0, 1'b0, c_eq, 5'd3,
                            reg_value(1), reg_value(2), reg_value(2)));
    compare_all("reg_form");
  endtask

  task automatic test_imm_forms();
    logic [11:0] imm12;
    logic [15:0] imm16;
    logic [8:0]  imm9;
    imm12 = 12'($urandom);
    imm16 = 16'($urandom);
    imm9  = 9'($urandom);
    send_expect(32'h91000000 | place_field(32'(imm12), 10) | place_field(1, 5) |
                place_field(5, 0),
                make_bundle(op_add, alu_plus, fu_alu, 1'b0, 1'b0, c_eq, 5'd5,
                            reg_value(1), 64'(imm12), 64'd0));
    send_expect(32'hD2800000 | place_field(32'(imm16), 5) | place_field(7, 0),
                make_bundle(op_movz, alu_mov, fu_alu, 1'b0, 1'b0, c_eq, 5'd7,
                            64'd0, 64'(imm16), 64'd0));
    send_expect(32'hF8400000 | place_field(32'(imm9), 12) | place_field(1, 5) |
                place_field(8, 0),
                make_bundle(op_ldur, alu_plus, fu_ls, 1'b0, 1'b0, c_eq, 5'd8,
                            reg_value(1), 64'(imm9), 64'd0));
    // Store data comes from Rt = x4, no destination
    send_expect(32'hF8000000 | place_field(32'(imm9), 12) | place_field(1, 5) |
                place_field(4, 0),
                make_bundle(op_stur, alu_plus, fu_ls, 1'b0, 1'b0, c_eq, zero_reg,
                            reg_value(1), 64'(imm9), reg_value(4)));
    compare_all("imm_forms");
  endtask

  task automatic test_cond_branch();
    logic [18:0] imm19;
    logic [25:0] imm26;
    imm19 = 19'($urandom);
    imm26 = 26'($urandom);
    send_expect(32'h9A800000 | place_field(2, 16) | place_field(32'(c_gt), 12) |
                place_field(1, 5) | place_field(9, 0),
                make_bundle(op_csel, alu_csel, fu_alu, 1'b0, 1'b1, c_gt, 5'd9,
                            reg_value(1), reg_value(2), reg_value(2)));
    send_expect(32'h54000000 | place_field(32'(imm19), 5) | place_field(32'(c_lt), 0),
                make_bundle(op_b_cond, alu_pass, fu_alu, 1'b0, 1'b1, c_lt, zero_reg,
                            64'd0, 64'd0, 64'd0));
    send_expect(32'h94000000 | place_field(32'(imm26), 0),
                make_bundle(op_bl, alu_pass, fu_alu, 1'b0, 1'b0, c_eq, link_reg,
                            64'd0, 64'd0, 64'd0));
    // ORR x11, xzr, x1 even though x31 was written earlier
    send_expect(32'hAA000000 | place_field(1, 16) | place_field(31, 5) | place_field(11, 0),
                make_bundle(op_orr, alu_or, fu_alu, 1'b0, 1'b0, c_eq, 5'd11,
                            64'd0, reg_value(1), reg_value(1)));
    compare_all("cond_branch");
  endtask

  task automatic test_illegal_nop();
    send_expect(32'h00000000,
                make_bundle(op_err, alu_pass, fu_alu, 1'b0, 1'b0, c_eq, 5'd0,
                            reg_value(0), 64'd0, 64'd0));
    send_expect(32'hD503201F,
                make_bundle(op_nop, alu_pass, fu_alu, 1'b0, 1'b0, c_eq, zero_reg,
                            64'd0, 64'd0, 64'd0));
    compare_all("illegal_nop");
  endtask

  task automatic test_timing();
    int k;
    // Single word strobed before edge N must show up right after edge N+3
    send_expect(32'h91000000 | place_field(7, 10) | place_field(2, 5) | place_field(12, 0),
                make_bundle(op_add, alu_plus, fu_alu, 1'b0, 1'b0, c_eq, 5'd12,
                            reg_value(2), 64'd7, 64'd0));
    for (k = 0; k <= 3; k++) begin
      if (k > 0) begin
        @(posedge in_clk);
      end
      @(negedge in_clk);
      check($sformatf("timing_single valid after N+%0d", k), 64'(k == 3), 64'(issue_valid));
    end
    @(posedge in_clk);
    #1;
    compare_all("timing_single");
    for (k = 0; k < 4; k++) begin
      send_expect(32'h91000000 | place_field(32'(k * 3 + 1), 10) | place_field(2, 5) |
                  place_field(32'(16 + k), 0),
                  make_bundle(op_add, alu_plus, fu_alu, 1'b0, 1'b0, c_eq, 5'(16 + k),
                              reg_value(2), 64'(k * 3 + 1), 64'd0));
    end
    while (got_q.size() < 4) begin
      @(posedge in_clk);
      #1;
    end
    for (k = 1; k < 4; k++) begin
      check($sformatf("timing_burst gap %0d", k), 64'd1, 64'(got_cyc[k] - got_cyc[k-1]));
    end
    compare_all("timing_burst");
  endtask

  task automatic test_stall();
    int i;
    in_stall = 1'b1;
    for (i = 0; i < fetch_depth; i++) begin
      send_expect(32'h91000000 | place_field(32'(i + 1), 10) | place_field(1, 5) |
                  place_field(32'(20 + i), 0),
                  make_bundle(op_add, alu_plus, fu_alu, 1'b0, 1'b0, c_eq, 5'(20 + i),
                              reg_value(1), 64'(i + 1), 64'd0));
    end
    repeat (8) @(posedge in_clk);
    @(negedge in_clk);
    check("stall no_issue", 64'd0, 64'(got_q.size()));
    check("stall overflow_before", 64'd0, 64'(fetch_overflow));
    @(posedge in_clk);
    #1;
    // Buffer is full, this word is dropped
    send_word(32'hD2800000 | place_field(16'hBEEF, 5) | place_field(25, 0));
    @(negedge in_clk);
    check("stall overflow", 64'd1, 64'(fetch_overflow));
    @(posedge in_clk);
    #1;
    in_stall = 1'b0;
    compare_all("stall");
    repeat (10) @(posedge in_clk);
    @(negedge in_clk);
    check("stall dropped_word", 64'd0, 64'(got_q.size()));
  endtask

  initial begin
    arst_n            = 1'b0;
    in_fetch_done     = 1'b0;
    in_fetch_insnbits = '0;
    in_stall          = 1'b0;
    wb_en             = 1'b0;
    wb_idx            = '0;
    wb_data           = '0;
    errors            = 0;
    checks            = 0;
    void'($urandom(18148));
    for (int i = 0; i < 32; i++) begin
      model[i] = '0;
    end
    repeat (2) @(posedge in_clk);
    #1;
    arst_n = 1'b1;
    check("reset issue_valid", 64'd0, 64'(issue_valid));
    check("reset fetch_overflow", 64'd0, 64'(fetch_overflow));
    write_reg(5'd1, {$urandom, $urandom});
    write_reg(5'd2, {$urandom, $urandom});
    write_reg(5'd4, {$urandom, $urandom});
    write_reg(5'd31, {$urandom, $urandom});
    test_reg_form();
    test_imm_forms();
    test_cond_branch();
    test_illegal_nop();
    test_timing();
    test_stall();
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
verilog/core_pkg.sv
verilog/fetch_buffer.sv
verilog/dispatch.sv
verilog/reg_file.sv
verilog/operand_stage.sv
verilog/frontend_top.sv
verification/frontend_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the frontend testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module frontend_tb -f project.f -o frontend_sim \
  && ./obj_dir/frontend_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
grep -q "sim failed" sim.log && exit 1
grep -q "sim passed" sim.log || exit 1
exit 0
